// File: verilog/fpu_pkg.sv
package fpu_pkg;

	typedef logic [4:0] reg_addr_t;

	localparam int FCC0_BIT    = 23;
	localparam int CAUSE_E_BIT = 17;
	localparam int FCSR_ADDR   = 31;
	localparam int FIR_ADDR    = 0;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  base;
		logic [4:0]  ft;
		logic [15:0] offset;
	} i_form_t;

	// For compares and MOVCF the cc index sits in the top bits of fd or ft
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] fmt;
		logic [4:0] ft;
		logic [4:0] fs;
		logic [4:0] fd;
		logic [5:0] funct;
	} r_form_t;

	typedef union packed {
		i_form_t i_form;
		r_form_t r_form;
	} inst_t;

	typedef enum logic [4:0] {
		FPU_OP_NOP, FPU_OP_LW, FPU_OP_SW, FPU_OP_MFC, FPU_OP_CFC, FPU_OP_MTC,
		FPU_OP_CTC, FPU_OP_ADD, FPU_OP_SUB, FPU_OP_MUL, FPU_OP_DIV, FPU_OP_SQRT,
		FPU_OP_ABS, FPU_OP_MOV, FPU_OP_NEG, FPU_OP_ROUND, FPU_OP_TRUNC, FPU_OP_CEIL,
		FPU_OP_FLOOR, FPU_OP_CVTW, FPU_OP_CVTS, FPU_OP_COND, FPU_OP_INVALID
	} fpu_op_t;

	typedef struct packed {
		fpu_op_t    op;
		reg_addr_t  raddr1;
		reg_addr_t  raddr2;
		logic       we;
		reg_addr_t  waddr;
		logic [2:0] cc;
		logic [3:0] cond;
	} fpu_dec_t;

	typedef enum logic [1:0] {
		EXC_NONE, EXC_UNIMPL, EXC_RESERVED
	} exc_t;

	typedef struct packed {
		logic        we;
		reg_addr_t   waddr;
		logic [31:0] wdata;
		logic        fcc_we;
		logic [2:0]  cc;
		logic        fcc_val;
		logic        fcsr_we;
		logic [31:0] fcsr_val;
		logic        out_en;
		logic [31:0] out_data;
		logic        fir_rd;
		exc_t        exc;
	} fpu_res_t;

	typedef struct packed {
		logic [6:0] fcc_hi;
		logic       fs;
		logic       fcc0;
		logic [4:0] zero;
		logic       cause_e;
		logic [4:0] cause;
		logic [4:0] enables;
		logic [4:0] flags;
		logic [1:0] rm;
	} fcsr_t;

endpackage

// File: verilog/fpu_id.sv
`timescale 1ns/1ps

module fpu_id (
	input  fpu_pkg::inst_t    inst,
	input  logic [7:0]        fcc,
	input  logic              gpr_zero,
	output fpu_pkg::fpu_dec_t dec
);

	fpu_pkg::reg_addr_t ft, fs, fd;
	logic fcc_match;

	assign ft = inst.r_form.ft;
	assign fs = inst.r_form.fs;
	assign fd = inst.r_form.fd;

	// MOVF/MOVT take cc from ft[4:2] and tf from ft[0]
	assign fcc_match = (fcc[ft[4:2]] == ft[0]);

	always_comb
	begin
		dec = '0;
		case (inst.i_form.opcode)
		6'b110001:
		begin
			dec.op    = fpu_pkg::FPU_OP_LW;
			dec.we    = 1'b1;
			dec.waddr = inst.i_form.ft;
		end
		6'b111001:
		begin
			dec.op     = fpu_pkg::FPU_OP_SW;
			dec.raddr1 = inst.i_form.ft;
		end
		6'b010001:
		begin
			case (inst.r_form.fmt)
			5'b00000:
			begin
				dec.op     = fpu_pkg::FPU_OP_MFC;
				dec.raddr2 = fs;
			end
			5'b00010:
			begin
				dec.op     = fpu_pkg::FPU_OP_CFC;
				dec.raddr2 = fs;
			end
			5'b00100:
			begin
				dec.op    = fpu_pkg::FPU_OP_MTC;
				dec.we    = 1'b1;
				dec.waddr = fs;
			end
			5'b00110:
			begin
				dec.op    = fpu_pkg::FPU_OP_CTC;
				dec.we    = 1'b1;
				dec.waddr = fs;
			end
			// BC1 is resolved by the integer core
			5'b01000: dec.op = fpu_pkg::FPU_OP_NOP;
			5'b10000:
			begin
				dec.raddr1 = fs;
				dec.raddr2 = ft;
				dec.waddr  = fd;
				dec.we     = 1'b1;
				casez (inst.r_form.funct)
				6'b000000: dec.op = fpu_pkg::FPU_OP_ADD;
				6'b000001: dec.op = fpu_pkg::FPU_OP_SUB;
				6'b000010: dec.op = fpu_pkg::FPU_OP_MUL;
				6'b000011: dec.op = fpu_pkg::FPU_OP_DIV;
				6'b000100: dec.op = fpu_pkg::FPU_OP_SQRT;
				6'b000101: dec.op = fpu_pkg::FPU_OP_ABS;
				6'b000110: dec.op = fpu_pkg::FPU_OP_MOV;
				6'b000111: dec.op = fpu_pkg::FPU_OP_NEG;
				6'b001100: dec.op = fpu_pkg::FPU_OP_ROUND;
				6'b001101: dec.op = fpu_pkg::FPU_OP_TRUNC;
				6'b001110: dec.op = fpu_pkg::FPU_OP_CEIL;
				6'b001111: dec.op = fpu_pkg::FPU_OP_FLOOR;
				6'b010001:
				begin
					dec.op     = fpu_pkg::FPU_OP_MOV;
					dec.raddr2 = 5'd0;
					dec.we     = fcc_match;
				end
				6'b010010:
				begin
					dec.op     = fpu_pkg::FPU_OP_MOV;
					dec.raddr2 = 5'd0;
					dec.we     = gpr_zero;
				end
				6'b010011:
				begin
					dec.op     = fpu_pkg::FPU_OP_MOV;
					dec.raddr2 = 5'd0;
					dec.we     = ~gpr_zero;
				end
				6'b100100: dec.op = fpu_pkg::FPU_OP_CVTW;
				6'b11????:
				begin
					dec.op    = fpu_pkg::FPU_OP_COND;
					dec.we    = 1'b0;
					dec.waddr = 5'd0;
					dec.cc    = fd[4:2];
					dec.cond  = inst.r_form.funct[3:0];
				end
				default:
				begin
					dec.op = fpu_pkg::FPU_OP_INVALID;
					dec.we = 1'b0;
				end
				endcase
			end
			5'b10100:
			begin
				if (inst.r_form.funct == 6'b100000)
				begin
					dec.op     = fpu_pkg::FPU_OP_CVTS;
					dec.raddr1 = fs;
					dec.raddr2 = ft;
					dec.we     = 1'b1;
					dec.waddr  = fd;
				end
				else
					dec.op = fpu_pkg::FPU_OP_INVALID;
			end
			default: dec.op = fpu_pkg::FPU_OP_INVALID;
			endcase
		end
		default: dec.op = fpu_pkg::FPU_OP_NOP;
		endcase
	end

	// A known instruction word decodes to a fully known control word
	always_comb
	begin
		if (!$isunknown(inst))
			a_op_known: assert final (!$isunknown(dec));
	end

endmodule

// File: verilog/fpu_regfile.sv
`timescale 1ns/1ps

module fpu_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  fpu_pkg::reg_addr_t raddr1,
	input  fpu_pkg::reg_addr_t raddr2,
	output logic [31:0]        rdata1,
	output logic [31:0]        rdata2,
	input  logic               wr_en,
	input  fpu_pkg::reg_addr_t wr_addr,
	input  logic [31:0]        wr_data
);

	logic [31:0] regs [32];

	// Reads see the old value during a write; fpu_ex forwards around it
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// File: verilog/fpu_ex.sv
`timescale 1ns/1ps

module fpu_ex (
	input  logic              clk,
	input  logic              rst_n,
	input  fpu_pkg::fpu_dec_t dec,
	input  logic              inst_valid,
	input  logic [31:0]       rdata1,
	input  logic [31:0]       rdata2,
	input  logic [31:0]       ext_data,
	input  fpu_pkg::fcsr_t    fcsr,
	output fpu_pkg::fpu_res_t res
);

	fpu_pkg::fpu_dec_t ex_dec;
	fpu_pkg::fcsr_t fcsr_q;
	logic [31:0] opnd1, opnd2, ext_q;
	logic [31:0] fwd1, fwd2, sgn_data;
	logic nan1, nan2, unord, both_zero, eq, lt, cmp;

	// The instruction in execute commits on the same edge that samples the next one
	assign fwd1 = (res.we && res.waddr == dec.raddr1) ? res.wdata : rdata1;
	assign fwd2 = (res.we && res.waddr == dec.raddr2) ? res.wdata : rdata2;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_dec <= '0;
		else
			ex_dec <= inst_valid ? dec : '0;
	end

	always_ff @(posedge clk)
	begin
		if (inst_valid)
		begin
			opnd1  <= fwd1;
			opnd2  <= fwd2;
			ext_q  <= ext_data;
			fcsr_q <= fcsr;
		end
	end

	assign nan1      = (&opnd1[30:23]) && (|opnd1[22:0]);
	assign nan2      = (&opnd2[30:23]) && (|opnd2[22:0]);
	assign unord     = nan1 | nan2;
	assign both_zero = (opnd1[30:0] == 31'h0) && (opnd2[30:0] == 31'h0);
	assign eq        = !unord && ((opnd1 == opnd2) || both_zero);

	always_comb
	begin
		// Sign-magnitude ordering, with +0 and -0 treated as equal
		if (opnd1[31] != opnd2[31])
			lt = opnd1[31] && !both_zero;
		else if (opnd1[31])
			lt = opnd1[30:0] > opnd2[30:0];
		else
			lt = opnd1[30:0] < opnd2[30:0];
		lt = lt && !unord;
	end

	assign cmp = (lt & ex_dec.cond[2]) | (eq & ex_dec.cond[1]) | (unord & ex_dec.cond[0]);

	always_comb
	begin
		case (ex_dec.op)
		fpu_pkg::FPU_OP_ABS: sgn_data = {1'b0, opnd1[30:0]};
		fpu_pkg::FPU_OP_NEG: sgn_data = {~opnd1[31], opnd1[30:0]};
		default:             sgn_data = opnd1;
		endcase
	end

	always_comb
	begin
		res         = '0;
		res.waddr   = ex_dec.waddr;
		res.cc      = ex_dec.cc;
		res.fcc_val = cmp;
		case (ex_dec.op)
		fpu_pkg::FPU_OP_LW, fpu_pkg::FPU_OP_MTC:
		begin
			res.we       = ex_dec.we;
			res.wdata    = ext_q;
			res.out_en   = 1'b1;
			res.out_data = ext_q;
		end
		fpu_pkg::FPU_OP_SW:
		begin
			res.out_en   = 1'b1;
			res.out_data = opnd1;
		end
		fpu_pkg::FPU_OP_MFC:
		begin
			res.out_en   = 1'b1;
			res.out_data = opnd2;
		end
		fpu_pkg::FPU_OP_CFC:
		begin
			res.out_en   = 1'b1;
			res.out_data = (ex_dec.raddr2 == fpu_pkg::FCSR_ADDR) ? fcsr_q : 32'h0;
			res.fir_rd   = (ex_dec.raddr2 == fpu_pkg::FIR_ADDR);
		end
		fpu_pkg::FPU_OP_CTC:
		begin
			res.fcsr_we  = (ex_dec.waddr == fpu_pkg::FCSR_ADDR);
			res.fcsr_val = ext_q;
			res.out_en   = 1'b1;
			res.out_data = ext_q;
		end
		fpu_pkg::FPU_OP_MOV, fpu_pkg::FPU_OP_ABS, fpu_pkg::FPU_OP_NEG:
		begin
			res.we       = ex_dec.we;
			res.wdata    = sgn_data;
			res.out_en   = 1'b1;
			res.out_data = sgn_data;
		end
		fpu_pkg::FPU_OP_COND:
		begin
			res.fcc_we   = 1'b1;
			res.out_en   = 1'b1;
			res.out_data = {31'h0, cmp};
		end
		fpu_pkg::FPU_OP_ADD, fpu_pkg::FPU_OP_SUB, fpu_pkg::FPU_OP_MUL,
		fpu_pkg::FPU_OP_DIV, fpu_pkg::FPU_OP_SQRT, fpu_pkg::FPU_OP_ROUND,
		fpu_pkg::FPU_OP_TRUNC, fpu_pkg::FPU_OP_CEIL, fpu_pkg::FPU_OP_FLOOR,
		fpu_pkg::FPU_OP_CVTW, fpu_pkg::FPU_OP_CVTS:
			res.exc = fpu_pkg::EXC_UNIMPL;
		fpu_pkg::FPU_OP_INVALID: res.exc = fpu_pkg::EXC_RESERVED;
		default: ;
		endcase
	end

	// A compare never finds its operands both equal and less
	a_cmp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_dec.op == fpu_pkg::FPU_OP_COND) |-> !(eq && lt));

endmodule

// File: verilog/fpu_wb.sv
`timescale 1ns/1ps

module fpu_wb #(
	parameter logic [31:0] FIR_VALUE = 32'h0001_0000
) (
	input  logic               clk,
	input  logic               rst_n,
	input  fpu_pkg::fpu_res_t  res,
	output logic               wr_en,
	output fpu_pkg::reg_addr_t wr_addr,
	output logic [31:0]        wr_data,
	output fpu_pkg::fcsr_t     fcsr,
	output logic [7:0]         fcc_fwd,
	output logic               out_valid,
	output logic [31:0]        out_data,
	output logic               exc_valid,
	output fpu_pkg::exc_t      exc_code
);

	fpu_pkg::fcsr_t fcsr_q, fcsr_nxt;

	assign wr_en   = res.we;
	assign wr_addr = res.waddr;
	assign wr_data = res.wdata;

	always_comb
	begin
		fcsr_nxt = fcsr_q;
		if (res.fcsr_we)
			fcsr_nxt = res.fcsr_val;
		if (res.fcc_we)
		begin
			if (res.cc == 3'd0)
				fcsr_nxt[fpu_pkg::FCC0_BIT] = res.fcc_val;
			else
				fcsr_nxt[fpu_pkg::FCC0_BIT + 1 + res.cc] = res.fcc_val;
		end
		if (res.exc == fpu_pkg::EXC_UNIMPL)
			fcsr_nxt[fpu_pkg::CAUSE_E_BIT] = 1'b1;
	end

	// Both views include the update of the instruction now in execute
	assign fcsr    = fcsr_nxt;
	assign fcc_fwd = {fcsr_nxt[31:25], fcsr_nxt[fpu_pkg::FCC0_BIT]};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fcsr_q    <= '0;
			out_valid <= 1'b0;
			exc_valid <= 1'b0;
		end
		else
		begin
			fcsr_q    <= fcsr_nxt;
			out_valid <= res.out_en;
			exc_valid <= (res.exc != fpu_pkg::EXC_NONE);
		end
	end

	always_ff @(posedge clk)
	begin
		if (res.out_en)
			out_data <= res.fir_rd ? FIR_VALUE : res.out_data;
		if (res.exc != fpu_pkg::EXC_NONE)
			exc_code <= res.exc;
	end

	// A result and an exception are never reported in the same cycle
	a_exc_alone: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && exc_valid));

endmodule

// File: verilog/fpu_top.sv
`timescale 1ns/1ps

module fpu_top #(
	parameter logic [31:0] FIR_VALUE = 32'h0001_0000
) (
	input  logic           clk,
	input  logic           rst_n,
	input  fpu_pkg::inst_t inst,
	input  logic           inst_valid,
	input  logic [31:0]    ext_data,
	input  logic           gpr_zero,
	output logic           out_valid,
	output logic [31:0]    out_data,
	output logic           exc_valid,
	output fpu_pkg::exc_t  exc_code
);

	fpu_pkg::fpu_dec_t dec;
	fpu_pkg::fpu_res_t res;
	fpu_pkg::fcsr_t fcsr;
	fpu_pkg::reg_addr_t wr_addr;
	logic [31:0] rdata1, rdata2, wr_data;
	logic [7:0] fcc_fwd;
	logic wr_en;

	fpu_id u_id (
		.inst     (inst),
		.fcc      (fcc_fwd),
		.gpr_zero (gpr_zero),
		.dec      (dec)
	);

	fpu_regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr1  (dec.raddr1),
		.raddr2  (dec.raddr2),
		.rdata1  (rdata1),
		.rdata2  (rdata2),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	fpu_ex u_ex (
		.clk        (clk),
		.rst_n      (rst_n),
		.dec        (dec),
		.inst_valid (inst_valid),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.ext_data   (ext_data),
		.fcsr       (fcsr),
		.res        (res)
	);

	fpu_wb #(
		.FIR_VALUE (FIR_VALUE)
	) u_wb (
		.clk       (clk),
		.rst_n     (rst_n),
		.res       (res),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.fcsr      (fcsr),
		.fcc_fwd   (fcc_fwd),
		.out_valid (out_valid),
		.out_data  (out_data),
		.exc_valid (exc_valid),
		.exc_code  (exc_code)
	);

endmodule

// File: bench/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb;

	localparam int PERIOD        = 40;
	localparam int RESET_CYCLES  = 16;
	localparam int ISSUE_BUDGET  = 200;
	localparam int WATCHDOG_NS   = (RESET_CYCLES + 20 * ISSUE_BUDGET) * PERIOD;
	localparam logic [31:0] FIR  = 32'h0001_A320;

	localparam logic [5:0] OP_LWC1 = 6'b110001;
	localparam logic [5:0] OP_SWC1 = 6'b111001;
	localparam logic [4:0] FMT_MFC = 5'b00000;
	localparam logic [4:0] FMT_CFC = 5'b00010;
	localparam logic [4:0] FMT_MTC = 5'b00100;
	localparam logic [4:0] FMT_CTC = 5'b00110;
	localparam logic [4:0] FMT_S   = 5'b10000;
	localparam logic [4:0] FMT_W   = 5'b10100;

	logic clk = 1'b0;
	logic rst_n;
	fpu_pkg::inst_t inst;
	logic inst_valid;
	logic [31:0] ext_data;
	logic gpr_zero;
	logic out_valid;
	logic [31:0] out_data;
	logic exc_valid;
	fpu_pkg::exc_t exc_code;

	logic [31:0] sh_regs [32];
	fpu_pkg::fcsr_t sh_fcsr;
	int checks = 0;
	int value_errors = 0;
	int strobe_errors = 0;

	fpu_top #(
		.FIR_VALUE (FIR)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.inst_valid (inst_valid),
		.ext_data   (ext_data),
		.gpr_zero   (gpr_zero),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.exc_valid  (exc_valid),
		.exc_code   (exc_code)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic fpu_pkg::inst_t cop1_word(input logic [4:0] fmt, input logic [4:0] ft,
		input logic [4:0] fs, input logic [4:0] fd, input logic [5:0] funct);
		fpu_pkg::inst_t w;
		w.r_form.opcode = 6'b010001;
		w.r_form.fmt    = fmt;
		w.r_form.ft     = ft;
		w.r_form.fs     = fs;
		w.r_form.fd     = fd;
		w.r_form.funct  = funct;
		return w;
	endfunction

	function automatic fpu_pkg::inst_t mem_word(input logic [5:0] opcode, input logic [4:0] ft);
		fpu_pkg::inst_t w;
		w.i_form.opcode = opcode;
		w.i_form.base   = 5'd0;
		w.i_form.ft     = ft;
		w.i_form.offset = 16'h0;
		return w;
	endfunction

	// Ordering key maps sign-magnitude onto plain signed integers, so -0 and +0 coincide
	function automatic logic float_compare(input logic [31:0] a, input logic [31:0] b,
		input logic [3:0] cond);
		logic unord, eq, lt;
		logic signed [32:0] ka, kb;
		unord = (a[30:23] == 8'hFF && a[22:0] != 23'h0) || (b[30:23] == 8'hFF && b[22:0] != 23'h0);
		ka = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
		kb = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
		eq = !unord && ((a == b) || (a[30:0] == 31'h0 && b[30:0] == 31'h0));
		lt = !unord && (ka < kb);
		return (lt && cond[2]) || (eq && cond[1]) || (unord && cond[0]);
	endfunction

	function automatic logic fcc_bit(input logic [2:0] cc);
		return (cc == 3'd0) ? sh_fcsr.fcc0 : sh_fcsr.fcc_hi[cc - 3'd1];
	endfunction

	task automatic set_fcc(input logic [2:0] cc, input logic val);
		if (cc == 3'd0)
			sh_fcsr.fcc0 = val;
		else
			sh_fcsr.fcc_hi[cc - 3'd1] = val;
	endtask

	task automatic check_out(input string name, input logic [31:0] exp);
		checks++;
		if (!out_valid)
		begin
			strobe_errors++;
			$display("Missing out_valid strobe for %s at %0t", name, $time);
		end
		else if (exc_valid)
		begin
			strobe_errors++;
			$display("Unexpected exception strobe alongside %s at %0t", name, $time);
		end
		else if (out_data !== exp)
		begin
			value_errors++;
			$display("** Error out_data (%s): got %h, expected %h", name, out_data, exp);
		end
	endtask

	task automatic check_exc(input fpu_pkg::exc_t exp);
		checks++;
		if (!exc_valid)
		begin
			strobe_errors++;
			$display("Missing exc_valid strobe at %0t, expected %s", $time, exp.name());
		end
		else if (out_valid)
		begin
			strobe_errors++;
			$display("out_valid rose together with exc_valid at %0t", $time);
		end
		else if (exc_code !== exp)
		begin
			value_errors++;
			$display("** Error exc_code: got %h, expected %h", exc_code, exp);
		end
	endtask

	task automatic check_fcsr(input fpu_pkg::fcsr_t exp);
		fpu_pkg::fcsr_t got;
		got = out_data;
		checks++;
		if (!out_valid)
		begin
			strobe_errors++;
			$display("Missing out_valid strobe for the FCSR read at %0t", $time);
		end
		else if (got !== exp)
		begin
			value_errors++;
			$display("** Error fcsr: got %h, expected %h", got, exp);
		end
	endtask

	// Returns on the falling edge right after the sampling edge
	task automatic issue(input fpu_pkg::inst_t w, input logic [31:0] ext, input logic gz);
		inst       = w;
		ext_data   = ext;
		gpr_zero   = gz;
		inst_valid = 1'b1;
		@(negedge clk);
		inst_valid = 1'b0;
	endtask

	task automatic execute_one(input fpu_pkg::inst_t w, input logic [31:0] ext, input logic gz);
		issue(w, ext, gz);
		@(negedge clk);
	endtask

	task automatic load_reg(input fpu_pkg::reg_addr_t r, input logic [31:0] v);
		execute_one(cop1_word(FMT_MTC, 5'd0, r, 5'd0, 6'd0), v, 1'b0);
		check_out($sformatf("mtc1 f%0d", r), v);
		sh_regs[r] = v;
	endtask

	task automatic read_back(input fpu_pkg::reg_addr_t r);
		execute_one(cop1_word(FMT_MFC, 5'd0, r, 5'd0, 6'd0), 32'h0, 1'b0);
		check_out($sformatf("mfc1 f%0d", r), sh_regs[r]);
	endtask

	task automatic write_fcsr(input logic [31:0] v);
		execute_one(cop1_word(FMT_CTC, 5'd0, 5'd31, 5'd0, 6'd0), v, 1'b0);
		check_out("ctc1", v);
		sh_fcsr = v;
	endtask

	task automatic fetch_fcsr();
		execute_one(cop1_word(FMT_CFC, 5'd0, 5'd31, 5'd0, 6'd0), 32'h0, 1'b0);
		check_fcsr(sh_fcsr);
	endtask

	task automatic reset_and_moves();
		logic [31:0] v;
		checks++;
		if (out_valid !== 1'b0 || exc_valid !== 1'b0)
		begin
			strobe_errors++;
			$display("An output strobe is high right after reset");
		end
		read_back(9);
		load_reg(3, $urandom());
		read_back(3);
		execute_one(mem_word(OP_SWC1, 5'd3), 32'h0, 1'b0);
		check_out("swc1 f3", sh_regs[3]);
		v = $urandom();
		execute_one(mem_word(OP_LWC1, 5'd7), v, 1'b0);
		check_out("lwc1 f7", v);
		sh_regs[7] = v;
		read_back(7);
	endtask

	task automatic sign_op(input logic [5:0] funct, input fpu_pkg::reg_addr_t fd,
		input logic [31:0] exp);
		execute_one(cop1_word(FMT_S, 5'd0, 5'd1, fd, funct), 32'h0, 1'b0);
		check_out($sformatf("sign op funct %h", funct), exp);
		sh_regs[fd] = exp;
		read_back(fd);
	endtask

	task automatic sign_ops();
		logic [31:0] v;
		for (int k = 0; k < 4; k++)
		begin
			v = $urandom();
			load_reg(1, v);
			sign_op(6'b000110, 5'd2, v);
			sign_op(6'b000101, 5'd3, {1'b0, v[30:0]});
			sign_op(6'b000111, 5'd4, {~v[31], v[30:0]});
		end
	endtask

	task automatic compare_pair(input logic [31:0] a, input logic [31:0] b);
		logic [2:0] cc;
		logic [3:0] cond;
		logic e;
		load_reg(10, a);
		load_reg(11, b);
		for (int c = 1; c < 8; c++)
		begin
			cc = 3'($urandom());
			cond = 4'(c);
			e = float_compare(a, b, cond);
			execute_one(cop1_word(FMT_S, 5'd11, 5'd10, {cc, 2'b00}, {2'b11, cond}), 32'h0, 1'b0);
			check_out($sformatf("c.cond.s %h", cond), {31'h0, e});
			set_fcc(cc, e);
		end
		fetch_fcsr();
	endtask

	task automatic guarded_move(input fpu_pkg::inst_t w, input logic gz, input logic copies);
		logic [31:0] v;
		v = $urandom();
		load_reg(21, v);
		load_reg(20, ~v);
		execute_one(w, 32'h0, gz);
		check_out("conditional move", v);
		if (copies)
			sh_regs[20] = v;
		read_back(20);
	endtask

	task automatic compares();
		compare_pair(32'h3F80_0000, 32'h4000_0000);
		compare_pair(32'h4049_0FDB, 32'h4049_0FDB);
		compare_pair(32'h0000_0000, 32'h8000_0000);
		compare_pair(32'h7FC0_0000, 32'h3F80_0000);
		compare_pair(32'hBF80_0000, 32'h3F80_0000);
		compare_pair(32'hC000_0000, 32'hBF80_0000);
		for (int t = 0; t < 2; t++)
		begin
			guarded_move(cop1_word(FMT_S, {3'd0, 1'b0, 1'(t)}, 5'd21, 5'd20, 6'b010001),
				1'b0, fcc_bit(3'd0) == 1'(t));
			guarded_move(cop1_word(FMT_S, {3'd5, 1'b0, 1'(t)}, 5'd21, 5'd20, 6'b010001),
				1'b0, fcc_bit(3'd5) == 1'(t));
			guarded_move(cop1_word(FMT_S, 5'd2, 5'd21, 5'd20, 6'b010010), 1'(t), t == 1);
			guarded_move(cop1_word(FMT_S, 5'd2, 5'd21, 5'd20, 6'b010011), 1'(t), t == 0);
		end
	endtask

	task automatic control_regs();
		write_fcsr($urandom());
		fetch_fcsr();
		execute_one(cop1_word(FMT_CFC, 5'd0, 5'd0, 5'd0, 6'd0), 32'h0, 1'b0);
		check_out("cfc1 fir", FIR);
		write_fcsr(32'h0);
		fetch_fcsr();
	endtask

	task automatic unimpl_op(input fpu_pkg::inst_t w);
		execute_one(w, 32'h0, 1'b0);
		check_exc(fpu_pkg::EXC_UNIMPL);
		sh_fcsr.cause_e = 1'b1;
		read_back(8);
	endtask

	task automatic exceptions();
		load_reg(8, $urandom());
		unimpl_op(cop1_word(FMT_S, 5'd2, 5'd1, 5'd8, 6'b000000));
		unimpl_op(cop1_word(FMT_S, 5'd2, 5'd1, 5'd8, 6'b000011));
		unimpl_op(cop1_word(FMT_S, 5'd0, 5'd1, 5'd8, 6'b100100));
		unimpl_op(cop1_word(FMT_W, 5'd0, 5'd1, 5'd8, 6'b100000));
		fetch_fcsr();
		write_fcsr(32'h0);
		// Reserved encodings trap without touching the cause bits
		execute_one(cop1_word(FMT_S, 5'd2, 5'd1, 5'd8, 6'b001000), 32'h0, 1'b0);
		check_exc(fpu_pkg::EXC_RESERVED);
		read_back(8);
		fetch_fcsr();
	endtask

	task automatic forwarding();
		logic [31:0] v;
		logic e;
		v = $urandom();
		issue(cop1_word(FMT_MTC, 5'd0, 5'd12, 5'd0, 6'd0), v, 1'b0);
		issue(cop1_word(FMT_S, 5'd0, 5'd12, 5'd13, 6'b000111), 32'h0, 1'b0);
		check_out("mtc1 f12", v);
		sh_regs[12] = v;
		issue(cop1_word(FMT_S, 5'd12, 5'd13, {3'd5, 2'b00}, 6'b110100), 32'h0, 1'b0);
		sh_regs[13] = {~v[31], v[30:0]};
		check_out("neg.s f13", sh_regs[13]);
		e = float_compare(sh_regs[13], sh_regs[12], 4'h4);
		issue(cop1_word(FMT_S, {3'd5, 2'b01}, 5'd12, 5'd14, 6'b010001), 32'h0, 1'b0);
		check_out("c.lt.s", {31'h0, e});
		set_fcc(3'd5, e);
		issue(cop1_word(FMT_MFC, 5'd0, 5'd14, 5'd0, 6'd0), 32'h0, 1'b0);
		check_out("movt.s", sh_regs[12]);
		if (e)
			sh_regs[14] = sh_regs[12];
		@(negedge clk);
		check_out("mfc1 f14", sh_regs[14]);
		fetch_fcsr();
	endtask

	initial
	begin
		void'($urandom(32'h68a3));
		rst_n      = 1'b0;
		inst       = '0;
		inst_valid = 1'b0;
		ext_data   = 32'h0;
		gpr_zero   = 1'b0;
		sh_fcsr    = '0;
		for (int r = 0; r < 32; r++)
			sh_regs[r] = 32'h0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reset_and_moves();
		sign_ops();
		compares();
		control_regs();
		exceptions();
		forwarding();
		$display("Checks: %0d, value errors: %0d, strobe errors: %0d",
			checks, value_errors, strobe_errors);
		if (value_errors == 0 && strobe_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t before the tests finished", $time);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: flist.f
verilog/fpu_pkg.sv
verilog/fpu_id.sv
verilog/fpu_regfile.sv
verilog/fpu_ex.sv
verilog/fpu_wb.sv
verilog/fpu_top.sv
bench/fpu_tb.sv
